/* design/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// datapath width, addresses and data alike
`define FETCH_XLEN 64

// first fetch address after reset, also the memory base
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// memory size in 64-bit words
`define FETCH_MEM_WORDS 256

// cycles from AR or last of AW/W to R or B valid
`define FETCH_MEM_LATENCY 3

// fill pattern, xored with the word index
`define FETCH_MEM_PATTERN 32'h5a3c_96e1

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`endif

/* design/fetch_pkg.sv */
`include "fetch_settings.svh"

package fetch_pkg;

  // program counter, full address width
  typedef logic [`FETCH_XLEN-1:0] pc_t;

  // one rv instruction, always 32 bits here
  typedef logic [31:0] inst_t;

  // request tag carried through the bus master
  typedef logic [3:0] req_id_t;

  // tag values per requester
  localparam req_id_t ID_FETCH = 4'd1;
  localparam req_id_t ID_DATA  = 4'd2;

endpackage

/* design/bus_pkg.sv */
`include "fetch_settings.svh"

package bus_pkg;

  // byte address on the memory bus
  typedef logic [`FETCH_XLEN-1:0] addr_t;

  // one bus word
  typedef logic [`FETCH_XLEN-1:0] data_t;

  // one strobe bit per data byte
  typedef logic [`FETCH_XLEN/8-1:0] strb_t;

  // axi response code
  typedef logic [1:0] resp_t;

  // only okay is ever returned
  localparam resp_t RESP_OKAY = 2'b00;

endpackage

/* design/pc_gen.sv */
`include "fetch_settings.svh"

module pc_gen
  import fetch_pkg::*;
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  redirect_i,
  input  pc_t   redirect_pc_i,
  input  logic  inst_ready_i,
  output logic  fetch_valid_o,
  output addr_t fetch_addr_o,
  input  logic  fetch_ready_i,
  input  logic  fetch_done_i,
  input  data_t fetch_data_i,
  output logic  inst_valid_o,
  output inst_t inst_o,
  output pc_t   inst_pc_o
);

  pc_t   pc_q;
  // fetch accepted by the arbiter, completion not yet seen
  logic  wait_q;
  // outstanding fetch belongs to the old path
  logic  stale_q;
  inst_t inst_q;
  addr_t req_addr_q;
  logic  fetch_hs;
  logic  inst_hs;
  logic  outstanding;
  logic  issue;

  assign fetch_hs    = fetch_valid_o & fetch_ready_i;
  assign inst_hs     = inst_valid_o & inst_ready_i;
  assign outstanding = fetch_valid_o | wait_q;
  // one fetch at a time, none while an instruction is held
  assign issue       = !outstanding && !inst_valid_o && !redirect_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= `FETCH_RESET_PC;
      fetch_valid_o <= 1'b0;
      wait_q        <= 1'b0;
      stale_q       <= 1'b0;
      inst_valid_o  <= 1'b0;
    end else begin
      // request stays up until the arbiter takes it
      if (issue) begin
        fetch_valid_o <= 1'b1;
      end else if (fetch_hs) begin
        fetch_valid_o <= 1'b0;
        wait_q        <= 1'b1;
      end
      if (fetch_done_i) begin
        wait_q <= 1'b0;
      end
      // redirect mid-flight, throw the returning word away
      if (fetch_done_i) begin
        stale_q <= 1'b0;
      end else if (redirect_i && outstanding) begin
        stale_q <= 1'b1;
      end
      // redirect wins over delivery and acceptance
      if (redirect_i) begin
        pc_q         <= redirect_pc_i;
        inst_valid_o <= 1'b0;
      end else if (fetch_done_i && !stale_q) begin
        inst_valid_o <= 1'b1;
      end else if (inst_hs) begin
        inst_valid_o <= 1'b0;
        pc_q         <= pc_q + pc_t'(4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_addr_q <= addr_t'(pc_q);
    end
    // pc bit 2 picks the half of the word
    if (fetch_done_i) begin
      inst_q <= pc_q[2] ? fetch_data_i[63:32] : fetch_data_i[31:0];
    end
  end

  // word aligned request
  assign fetch_addr_o = {req_addr_q[`FETCH_XLEN-1:3], 3'b000};
  // pc only advances on acceptance, so it names the held instruction
  assign inst_pc_o    = pc_q;
  assign inst_o       = inst_valid_o ? inst_q : inst_t'(`FETCH_NOP);

endmodule

/* design/req_arbiter.sv */
module req_arbiter
  import fetch_pkg::*;
  import bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    fetch_valid_i,
  input  addr_t   fetch_addr_i,
  output logic    fetch_ready_o,
  output logic    fetch_done_o,
  output data_t   fetch_data_o,
  input  logic    data_valid_i,
  input  logic    data_we_i,
  input  addr_t   data_addr_i,
  input  data_t   data_wdata_i,
  input  strb_t   data_strb_i,
  output logic    data_ready_o,
  output logic    data_rvalid_o,
  output data_t   data_rdata_o,
  output logic    data_wdone_o,
  output logic    bus_valid_o,
  output logic    bus_we_o,
  output req_id_t bus_id_o,
  output addr_t   bus_addr_o,
  output data_t   bus_wdata_o,
  output strb_t   bus_strb_o,
  input  logic    bus_ready_i,
  input  logic    bus_done_i,
  input  req_id_t bus_done_id_i,
  input  data_t   bus_rdata_i
);

  // one request in flight, grant to done
  logic busy_q;
  // kind of the data request in flight
  logic we_q;
  logic grant;
  logic done_data;

  // data side has priority
  assign bus_valid_o = !busy_q && (data_valid_i || fetch_valid_i);
  assign grant       = bus_valid_o && bus_ready_i;

  // loser keeps its valid and sees no ready
  assign data_ready_o  = grant && data_valid_i;
  assign fetch_ready_o = grant && !data_valid_i;

  assign bus_we_o    = data_valid_i && data_we_i;
  assign bus_id_o    = data_valid_i ? ID_DATA : ID_FETCH;
  assign bus_addr_o  = data_valid_i ? data_addr_i : fetch_addr_i;
  assign bus_wdata_o = data_valid_i ? data_wdata_i : '0;
  assign bus_strb_o  = data_valid_i ? data_strb_i : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      we_q   <= 1'b0;
    end else if (grant) begin
      busy_q <= 1'b1;
      we_q   <= bus_we_o;
    end else if (bus_done_i) begin
      busy_q <= 1'b0;
    end
  end

  // completion routed by returned id, no added cycles
  assign done_data     = bus_done_i && (bus_done_id_i == ID_DATA);
  assign fetch_done_o  = bus_done_i && (bus_done_id_i == ID_FETCH);
  assign fetch_data_o  = bus_rdata_i;
  assign data_rvalid_o = done_data && !we_q;
  assign data_wdone_o  = done_data && we_q;
  assign data_rdata_o  = bus_rdata_i;

endmodule

/* design/bus_master.sv */
module bus_master
  import fetch_pkg::*;
  import bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    bus_valid_i,
  input  logic    bus_we_i,
  input  req_id_t bus_id_i,
  input  addr_t   bus_addr_i,
  input  data_t   bus_wdata_i,
  input  strb_t   bus_strb_i,
  output logic    bus_ready_o,
  output logic    bus_done_o,
  output req_id_t bus_done_id_o,
  output data_t   bus_rdata_o,
  output logic    ar_valid_o,
  output addr_t   ar_addr_o,
  output req_id_t ar_id_o,
  input  logic    ar_ready_i,
  input  logic    r_valid_i,
  input  data_t   r_data_i,
  input  resp_t   r_resp_i,
  input  logic    r_last_i,
  output logic    r_ready_o,
  output logic    aw_valid_o,
  output addr_t   aw_addr_o,
  input  logic    aw_ready_i,
  output logic    w_valid_o,
  output data_t   w_data_o,
  output strb_t   w_strb_o,
  output logic    w_last_o,
  input  logic    w_ready_i,
  input  logic    b_valid_i,
  output logic    b_ready_o
);

  typedef enum logic [1:0] {S_IDLE, S_ADDR, S_WAIT_R, S_WAIT_B} state_t;

  state_t  state_q;
  logic    we_q;
  req_id_t id_q;
  addr_t   addr_q;
  data_t   wdata_q;
  strb_t   strb_q;
  data_t   rdata_q;
  logic    r_final;
  logic    b_hs;

  assign bus_ready_o = (state_q == S_IDLE);
  // read data always taken
  assign r_ready_o   = 1'b1;
  assign b_ready_o   = (state_q == S_WAIT_B);
  // single beat, every read ends on its only beat
  assign r_final     = r_valid_i && r_ready_o && r_last_i;
  assign b_hs        = b_valid_i && b_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= S_IDLE;
      ar_valid_o <= 1'b0;
      aw_valid_o <= 1'b0;
      w_valid_o  <= 1'b0;
      bus_done_o <= 1'b0;
    end else begin
      bus_done_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          // address phase opens the cycle after acceptance
          if (bus_valid_i) begin
            state_q    <= S_ADDR;
            ar_valid_o <= !bus_we_i;
            aw_valid_o <= bus_we_i;
            w_valid_o  <= bus_we_i;
          end
        end
        S_ADDR: begin
          if (we_q) begin
            // aw and w complete independently
            if (aw_ready_i) begin
              aw_valid_o <= 1'b0;
            end
            if (w_ready_i) begin
              w_valid_o <= 1'b0;
            end
            if ((!aw_valid_o || aw_ready_i) && (!w_valid_o || w_ready_i)) begin
              state_q <= S_WAIT_B;
            end
          end else if (ar_ready_i) begin
            ar_valid_o <= 1'b0;
            state_q    <= S_WAIT_R;
          end
        end
        S_WAIT_R: begin
          if (r_final) begin
            state_q    <= S_IDLE;
            bus_done_o <= 1'b1;
          end
        end
        default: begin
          if (b_hs) begin
            state_q    <= S_IDLE;
            bus_done_o <= 1'b1;
          end
        end
      endcase
    end
  end

  // request latched on grant, held for the whole transaction
  always_ff @(posedge clk) begin
    if (bus_valid_i && bus_ready_o) begin
      we_q    <= bus_we_i;
      id_q    <= bus_id_i;
      addr_q  <= bus_addr_i;
      wdata_q <= bus_wdata_i;
      strb_q  <= bus_strb_i;
    end
    // error beats read back as zero
    if (state_q == S_WAIT_R && r_final) begin
      rdata_q <= (r_resp_i == RESP_OKAY) ? r_data_i : '0;
    end
  end

  assign ar_addr_o     = addr_q;
  assign ar_id_o       = id_q;
  assign aw_addr_o     = addr_q;
  assign w_data_o      = wdata_q;
  assign w_strb_o      = strb_q;
  assign w_last_o      = 1'b1;
  assign bus_done_id_o = id_q;
  assign bus_rdata_o   = rdata_q;

endmodule

/* design/mem_slave.sv */
`include "fetch_settings.svh"

module mem_slave
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  ar_valid_i,
  input  addr_t ar_addr_i,
  output logic  ar_ready_o,
  output logic  r_valid_o,
  output data_t r_data_o,
  output resp_t r_resp_o,
  output logic  r_last_o,
  input  logic  r_ready_i,
  input  logic  aw_valid_i,
  input  addr_t aw_addr_i,
  output logic  aw_ready_o,
  input  logic  w_valid_i,
  input  data_t w_data_i,
  input  strb_t w_strb_i,
  input  logic  w_last_i,
  output logic  w_ready_o,
  output logic  b_valid_o,
  input  logic  b_ready_i
);

  localparam int IDX_W = $clog2(`FETCH_MEM_WORDS);
  localparam int CNT_W = $clog2(`FETCH_MEM_LATENCY + 1);

  typedef enum logic [1:0] {S_IDLE, S_WAIT, S_RESP} state_t;

  state_t           state_q;
  data_t            mem [`FETCH_MEM_WORDS];
  logic [IDX_W-1:0] idx_q;
  logic [CNT_W-1:0] cnt_q;
  logic             write_q;
  logic             aw_got_q;
  logic             w_got_q;
  data_t            wdata_q;
  strb_t            wstrb_q;
  logic             ar_hs;
  logic             aw_hs;
  logic             w_hs;
  logic             write_go;
  logic             fire;

  // offset from base, word index from bits [10:3]
  function automatic logic [IDX_W-1:0] word_idx(input addr_t a);
    addr_t off;
    off = a - addr_t'(`FETCH_RESET_PC);
    return off[IDX_W+2:3];
  endfunction

  // reads win if both arrive together
  assign ar_ready_o = (state_q == S_IDLE) && !aw_got_q && !w_got_q;
  assign aw_ready_o = (state_q == S_IDLE) && !aw_got_q && !ar_valid_i;
  assign w_ready_o  = (state_q == S_IDLE) && !w_got_q && !ar_valid_i;
  assign ar_hs      = ar_valid_i && ar_ready_o;
  assign aw_hs      = aw_valid_i && aw_ready_o;
  assign w_hs       = w_valid_i && w_ready_o;
  // latency counts from the later of aw and last w
  assign write_go   = (aw_got_q || aw_hs) && (w_got_q || (w_hs && w_last_i));
  assign fire       = (state_q == S_WAIT) && (cnt_q == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      cnt_q     <= '0;
      write_q   <= 1'b0;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      r_valid_o <= 1'b0;
      b_valid_o <= 1'b0;
      // low half k xor pattern, high half its complement
      for (int k = 0; k < `FETCH_MEM_WORDS; k++) begin
        mem[k] <= {~(32'(k) ^ `FETCH_MEM_PATTERN), 32'(k) ^ `FETCH_MEM_PATTERN};
      end
    end else begin
      case (state_q)
        S_IDLE: begin
          if (ar_hs || write_go) begin
            write_q  <= !ar_hs;
            aw_got_q <= 1'b0;
            w_got_q  <= 1'b0;
            cnt_q    <= CNT_W'(`FETCH_MEM_LATENCY - 1);
            state_q  <= S_WAIT;
          end else begin
            aw_got_q <= aw_got_q || aw_hs;
            w_got_q  <= w_got_q || (w_hs && w_last_i);
          end
        end
        S_WAIT: begin
          if (!fire) begin
            cnt_q <= cnt_q - 1'b1;
          end else begin
            state_q   <= S_RESP;
            r_valid_o <= !write_q;
            b_valid_o <= write_q;
            // byte lane merge
            if (write_q) begin
              for (int b = 0; b < $bits(strb_t); b++) begin
                if (wstrb_q[b]) begin
                  mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
                end
              end
            end
          end
        end
        default: begin
          // response held until taken
          if ((r_valid_o && r_ready_i) || (b_valid_o && b_ready_i)) begin
            r_valid_o <= 1'b0;
            b_valid_o <= 1'b0;
            state_q   <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      idx_q <= word_idx(ar_addr_i);
    end else if (aw_hs) begin
      idx_q <= word_idx(aw_addr_i);
    end
    if (w_hs) begin
      wdata_q <= w_data_i;
      wstrb_q <= w_strb_i;
    end
    if (fire && !write_q) begin
      r_data_o <= mem[idx_q];
    end
  end

  assign r_resp_o = RESP_OKAY;
  assign r_last_o = 1'b1;

endmodule

/* design/fetch_unit.sv */
module fetch_unit
  import fetch_pkg::*;
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  redirect_i,
  input  pc_t   redirect_pc_i,
  input  logic  inst_ready_i,
  output logic  inst_valid_o,
  output inst_t inst_o,
  output pc_t   inst_pc_o,
  input  logic  data_valid_i,
  input  logic  data_we_i,
  input  addr_t data_addr_i,
  input  data_t data_wdata_i,
  input  strb_t data_strb_i,
  output logic  data_ready_o,
  output logic  data_rvalid_o,
  output data_t data_rdata_o,
  output logic  data_wdone_o
);

  // fetch side
  logic    fetch_valid, fetch_ready, fetch_done;
  addr_t   fetch_addr;
  data_t   fetch_data;
  // granted request and its completion
  logic    bus_valid, bus_we, bus_ready, bus_done;
  req_id_t bus_id, bus_done_id;
  addr_t   bus_addr, ar_addr, aw_addr;
  data_t   bus_wdata, bus_rdata, r_data, w_data;
  strb_t   bus_strb, w_strb;
  // axi channels
  logic    ar_valid, ar_ready, r_valid, r_last, r_ready;
  logic    aw_valid, aw_ready, w_valid, w_last, w_ready, b_valid, b_ready;
  resp_t   r_resp;

  pc_gen u_pc_gen (
    .clk, .rst_n, .redirect_i, .redirect_pc_i, .inst_ready_i,
    .fetch_valid_o(fetch_valid), .fetch_addr_o(fetch_addr), .fetch_ready_i(fetch_ready),
    .fetch_done_i(fetch_done), .fetch_data_i(fetch_data),
    .inst_valid_o, .inst_o, .inst_pc_o
  );

  req_arbiter u_req_arbiter (
    .clk, .rst_n,
    .fetch_valid_i(fetch_valid), .fetch_addr_i(fetch_addr), .fetch_ready_o(fetch_ready),
    .fetch_done_o(fetch_done), .fetch_data_o(fetch_data),
    .data_valid_i, .data_we_i, .data_addr_i, .data_wdata_i, .data_strb_i,
    .data_ready_o, .data_rvalid_o, .data_rdata_o, .data_wdone_o,
    .bus_valid_o(bus_valid), .bus_we_o(bus_we), .bus_id_o(bus_id), .bus_addr_o(bus_addr),
    .bus_wdata_o(bus_wdata), .bus_strb_o(bus_strb), .bus_ready_i(bus_ready),
    .bus_done_i(bus_done), .bus_done_id_i(bus_done_id), .bus_rdata_i(bus_rdata)
  );

  // slave has no read id, ar_id stays inside the master
  bus_master u_bus_master (
    .clk, .rst_n,
    .bus_valid_i(bus_valid), .bus_we_i(bus_we), .bus_id_i(bus_id), .bus_addr_i(bus_addr),
    .bus_wdata_i(bus_wdata), .bus_strb_i(bus_strb), .bus_ready_o(bus_ready),
    .bus_done_o(bus_done), .bus_done_id_o(bus_done_id), .bus_rdata_o(bus_rdata),
    .ar_valid_o(ar_valid), .ar_addr_o(ar_addr), .ar_id_o(), .ar_ready_i(ar_ready),
    .r_valid_i(r_valid), .r_data_i(r_data), .r_resp_i(r_resp), .r_last_i(r_last),
    .r_ready_o(r_ready),
    .aw_valid_o(aw_valid), .aw_addr_o(aw_addr), .aw_ready_i(aw_ready),
    .w_valid_o(w_valid), .w_data_o(w_data), .w_strb_o(w_strb), .w_last_o(w_last),
    .w_ready_i(w_ready), .b_valid_i(b_valid), .b_ready_o(b_ready)
  );

  mem_slave u_mem_slave (
    .clk, .rst_n,
    .ar_valid_i(ar_valid), .ar_addr_i(ar_addr), .ar_ready_o(ar_ready),
    .r_valid_o(r_valid), .r_data_o(r_data), .r_resp_o(r_resp), .r_last_o(r_last),
    .r_ready_i(r_ready),
    .aw_valid_i(aw_valid), .aw_addr_i(aw_addr), .aw_ready_o(aw_ready),
    .w_valid_i(w_valid), .w_data_i(w_data), .w_strb_i(w_strb), .w_last_i(w_last),
    .w_ready_o(w_ready), .b_valid_o(b_valid), .b_ready_i(b_ready)
  );

endmodule

/* bench/fetch_unit_assertions.sv */
module fetch_unit_assertions
  import fetch_pkg::*;
  import bus_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  ar_valid_i,
  input addr_t ar_addr_i,
  input logic  ar_ready_i,
  input logic  aw_valid_i,
  input addr_t aw_addr_i,
  input logic  aw_ready_i,
  input logic  w_valid_i,
  input data_t w_data_i,
  input strb_t w_strb_i,
  input logic  w_ready_i,
  input logic  grant_valid_i,
  input logic  master_idle_i,
  input logic  redirect_i,
  input logic  inst_ready_i,
  input logic  inst_valid_i,
  input inst_t inst_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // address and write channels hold until ready
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
    else $error("AR valid dropped or address changed before ready");

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i))
    else $error("AW valid dropped or address changed before ready");

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_data_i) && $stable(w_strb_i))
    else $error("W valid dropped or payload changed before ready");

  // held instruction under back-pressure
  inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_i && !inst_ready_i && !redirect_i |=> inst_valid_i && $stable(inst_i))
    else $error("held instruction changed without acceptance or redirect");

  // grant only reaches an idle master
  grant_idle: assert property (@(posedge clk) disable iff (!rst_n)
    grant_valid_i |-> master_idle_i)
    else $error("arbiter granted while a transaction was in flight");

endmodule

// bus side, instruction ports tied off
bind bus_master fetch_unit_assertions u_bus_asrt (
  .clk, .rst_n,
  .ar_valid_i(ar_valid_o), .ar_addr_i(ar_addr_o), .ar_ready_i,
  .aw_valid_i(aw_valid_o), .aw_addr_i(aw_addr_o), .aw_ready_i,
  .w_valid_i(w_valid_o), .w_data_i(w_data_o), .w_strb_i(w_strb_o), .w_ready_i,
  .grant_valid_i(bus_valid_i), .master_idle_i(bus_ready_o),
  .redirect_i(1'b0), .inst_ready_i(1'b1), .inst_valid_i(1'b0), .inst_i('0)
);

// fetch side, bus ports tied off
bind pc_gen fetch_unit_assertions u_fetch_asrt (
  .clk, .rst_n,
  .ar_valid_i(1'b0), .ar_addr_i('0), .ar_ready_i(1'b1),
  .aw_valid_i(1'b0), .aw_addr_i('0), .aw_ready_i(1'b1),
  .w_valid_i(1'b0), .w_data_i('0), .w_strb_i('0), .w_ready_i(1'b1),
  .grant_valid_i(1'b0), .master_idle_i(1'b1),
  .redirect_i, .inst_ready_i, .inst_valid_i(inst_valid_o), .inst_i(inst_o)
);

/* bench/fetch_unit_tb.sv */
`include "fetch_settings.svh"

module fetch_unit_tb
  import fetch_pkg::*;
  import bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_HALF = 2;
  localparam int MEM_WORDS = `FETCH_MEM_WORDS;
  // generous bound per transaction, covers arbitration and back-pressure
  localparam int CYC_PER_TXN = 60;
  localparam int N_SEQ = 64;
  localparam int N_REDIR = 80;
  localparam int N_DATA = 48;
  localparam int N_MIX_I = 60;
  localparam int N_MIX_D = 40;
  localparam int N_TOTAL = 1 + N_SEQ + N_REDIR + N_DATA + N_MIX_I + N_MIX_D;
  localparam int WATCHDOG_NS = (N_TOTAL + 10) * CYC_PER_TXN * 2 * CLK_HALF + 100;

  logic  clk;
  logic  rst_n;
  logic  redirect_i;
  pc_t   redirect_pc_i;
  logic  inst_ready_i;
  logic  inst_valid_o;
  inst_t inst_o;
  pc_t   inst_pc_o;
  logic  data_valid_i;
  logic  data_we_i;
  addr_t data_addr_i;
  data_t data_wdata_i;
  strb_t data_strb_i;
  logic  data_ready_o;
  logic  data_rvalid_o;
  data_t data_rdata_o;
  logic  data_wdone_o;

  logic [31:0] lfsr_q;
  // reference memory and fetch state
  data_t mem_model [MEM_WORDS];
  pc_t   pc_model;
  inst_t exp_inst;
  logic  prev_valid;
  // data request in flight
  logic  data_pend;
  logic  data_busy;
  logic  exp_we;
  addr_t exp_addr;
  data_t exp_wdata;
  strb_t exp_strb;
  // stimulus knobs, thresholds out of 256
  int    ready_thr;
  int    redir_thr;
  int    data_thr;
  int    data_target;
  int    we_mode;
  int    write_until;
  logic  addr_near_pc;
  int    n_accept;
  int    n_data_issued;
  int    n_data_done;
  int    errors;
  int    tests_run;
  int    tests_failed;

  fetch_unit uut (
    .clk, .rst_n, .redirect_i, .redirect_pc_i, .inst_ready_i,
    .inst_valid_o, .inst_o, .inst_pc_o,
    .data_valid_i, .data_we_i, .data_addr_i, .data_wdata_i, .data_strb_i,
    .data_ready_o, .data_rvalid_o, .data_rdata_o, .data_wdone_o
  );

  initial clk = 1'b0;
  always #(CLK_HALF) clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // word index relative to the memory base, wraps at the array size
  function automatic int word_of(input addr_t a);
    addr_t off;
    off = a - addr_t'(`FETCH_RESET_PC);
    return int'((off >> 3) % MEM_WORDS);
  endfunction

  function automatic data_t fill_word(input int k);
    logic [31:0] lo;
    lo = 32'(k) ^ `FETCH_MEM_PATTERN;
    return {~lo, lo};
  endfunction

  function automatic inst_t half_of(input data_t w, input pc_t pc);
    return pc[2] ? w[63:32] : w[31:0];
  endfunction

  task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s mismatch, got %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic merge_write(input addr_t a, input data_t d, input strb_t s);
    int k;
    k = word_of(a);
    for (int b = 0; b < 8; b++) begin
      if (s[b]) begin
        mem_model[k][8*b +: 8] = d[8*b +: 8];
      end
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] hi;
    logic [7:0]  w8;
    take_bits(8, r);
    inst_ready_i = (int'(r[7:0]) < ready_thr);
    take_bits(8, r);
    redirect_i = (int'(r[7:0]) < redir_thr);
    if (redirect_i) begin
      // any instruction slot inside the memory
      take_bits(9, r);
      redirect_pc_i = pc_t'(`FETCH_RESET_PC) + pc_t'({r[8:0], 2'b00});
    end
    // accepted on the last edge
    if (data_valid_i && !data_pend) begin
      data_valid_i = 1'b0;
    end
    take_bits(8, r);
    if (!data_pend && !data_busy && n_data_issued < data_target && int'(r[7:0]) < data_thr) begin
      take_bits(4, r);
      // near the fetch stream, or a small fixed pool
      if (addr_near_pc) begin
        w8 = 8'(word_of(pc_model) + int'(r[2:0]));
      end else begin
        w8 = 8'(16 + int'(r[3:0]));
      end
      take_bits(1, r);
      if (we_mode == 1) begin
        data_we_i = (n_data_issued < write_until);
      end else begin
        data_we_i = r[0];
      end
      take_bits(32, r);
      take_bits(32, hi);
      data_wdata_i = {hi, r};
      take_bits(8, r);
      data_strb_i  = r[7:0];
      data_addr_i  = addr_t'(`FETCH_RESET_PC) + addr_t'({w8, 3'b000});
      data_valid_i = 1'b1;
      exp_we    = data_we_i;
      exp_addr  = data_addr_i;
      exp_wdata = data_wdata_i;
      exp_strb  = data_strb_i;
      data_pend = 1'b1;
      n_data_issued++;
    end
  endtask

  task automatic sample_outputs();
    if (data_rvalid_o || data_wdone_o) begin
      if (!data_busy || (data_rvalid_o && data_wdone_o)) begin
        errors++;
        $display("unexpected data completion pulse at %0t ns", $time);
      end else begin
        check_eq(64'(data_wdone_o), 64'(exp_we), "data completion kind");
        if (exp_we) begin
          merge_write(exp_addr, exp_wdata, exp_strb);
        end else begin
          check_eq(data_rdata_o, mem_model[word_of(exp_addr)], "data read value");
        end
        data_busy = 1'b0;
        n_data_done++;
      end
    end
    if (data_valid_i && data_ready_o) begin
      data_pend = 1'b0;
      data_busy = 1'b1;
    end
    // memory content at the time the fetch returned
    if (inst_valid_o && !prev_valid) begin
      exp_inst = half_of(mem_model[word_of(pc_model)], pc_model);
    end
    if (!inst_valid_o) begin
      check_eq(64'(inst_o), 64'(`FETCH_NOP), "idle instruction");
    end
    // redirect beats acceptance
    if (redirect_i) begin
      pc_model = redirect_pc_i;
    end else if (inst_valid_o && inst_ready_i) begin
      check_eq(inst_pc_o, pc_model, "accepted pc");
      check_eq(64'(inst_o), 64'(exp_inst), "accepted instruction");
      pc_model = pc_model + pc_t'(4);
      n_accept++;
    end
    prev_valid = inst_valid_o && !inst_ready_i && !redirect_i;
  endtask

  task automatic cycle();
    @(posedge clk);
    #1;
    drive_inputs();
    @(negedge clk);
    sample_outputs();
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  task automatic run_test(input string name, input int n_inst, input int n_data);
    int err_before;
    int acc0;
    int done0;
    int cycles;
    int limit;
    err_before  = errors;
    acc0        = n_accept;
    done0       = n_data_done;
    cycles      = 0;
    limit       = (n_inst + n_data + 1) * CYC_PER_TXN;
    data_target = n_data_issued + n_data;
    while (((n_accept - acc0) < n_inst || (n_data_done - done0) < n_data) && cycles < limit) begin
      cycle();
      cycles++;
    end
    if (cycles >= limit) begin
      errors++;
      $display("%s did not finish within %0d cycles", name, limit);
    end
    finish_test(name, err_before);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: the run timed out after %0d ns", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    int err_before;
    int waited;
    lfsr_q        = 32'h0ebd_b4ad;
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    inst_ready_i  = 1'b0;
    data_valid_i  = 1'b0;
    data_we_i     = 1'b0;
    data_addr_i   = '0;
    data_wdata_i  = '0;
    data_strb_i   = '0;
    for (int k = 0; k < MEM_WORDS; k++) begin
      mem_model[k] = fill_word(k);
    end
    pc_model      = `FETCH_RESET_PC;
    exp_inst      = '0;
    prev_valid    = 1'b0;
    data_pend     = 1'b0;
    data_busy     = 1'b0;
    exp_we        = 1'b0;
    exp_addr      = '0;
    exp_wdata     = '0;
    exp_strb      = '0;
    ready_thr     = 0;
    redir_thr     = 0;
    data_thr      = 0;
    data_target   = 0;
    we_mode       = 0;
    write_until   = 0;
    addr_near_pc  = 1'b0;
    n_accept      = 0;
    n_data_issued = 0;
    n_data_done   = 0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset state, then the first fetch
    err_before = errors;
    @(negedge clk);
    check_eq(64'(inst_valid_o), 64'(0), "inst valid after reset");
    check_eq(64'(data_ready_o), 64'(0), "data ready after reset");
    check_eq(64'(inst_o), 64'(`FETCH_NOP), "instruction after reset");
    waited = 0;
    while (!inst_valid_o && waited < CYC_PER_TXN) begin
      cycle();
      waited++;
    end
    if (!inst_valid_o) begin
      errors++;
      $display("first instruction never became valid");
    end else begin
      check_eq(inst_pc_o, `FETCH_RESET_PC, "first pc");
      check_eq(64'(inst_o), 64'(`FETCH_MEM_PATTERN), "first instruction");
    end
    ready_thr = 256;
    waited    = 0;
    while (n_accept < 1 && waited < CYC_PER_TXN) begin
      cycle();
      waited++;
    end
    finish_test("reset and first fetch", err_before);

    ready_thr = 128;
    run_test("sequential fetch", N_SEQ, 0);

    ready_thr = 160;
    redir_thr = 8;
    run_test("random redirects", N_REDIR, 0);

    // fetch held, writes first then reads over a 16 word pool
    ready_thr   = 0;
    redir_thr   = 0;
    data_thr    = 128;
    we_mode     = 1;
    write_until = n_data_issued + N_DATA / 2;
    run_test("data write and read", 0, N_DATA);

    ready_thr    = 160;
    redir_thr    = 4;
    data_thr     = 40;
    we_mode      = 0;
    addr_near_pc = 1'b1;
    run_test("mixed data and fetch", N_MIX_I, N_MIX_D);

    $display("summary: %0d tests, %0d failed, %0d errors, %0d instructions, %0d data requests",
             tests_run, tests_failed, errors, n_accept, n_data_done);
    if (tests_failed == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+design
design/fetch_pkg.sv
design/bus_pkg.sv
design/pc_gen.sv
design/req_arbiter.sv
design/bus_master.sv
design/mem_slave.sv
design/fetch_unit.sv
bench/fetch_unit_assertions.sv
bench/fetch_unit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fetch unit testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
  -f vlog.f --top-module fetch_unit_tb -o fetch_unit_sim
./obj_dir/fetch_unit_sim | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
